/* hdl/agu_config.svh */
`ifndef AGU_CONFIG_SVH
`define AGU_CONFIG_SVH

// data path and virtual address width
`define AGU_XLEN 32

// width of the offset field in the instruction
`define AGU_OFFSET_W 16

// reorder buffer tag
`define AGU_ROB_W 4

// physical register number
`define AGU_DEST_W 6

// address error exception codes
`define AGU_EXC_ADEL 5'd4
`define AGU_EXC_ADES 5'd5

// entries in each skid queue
`define AGU_QUEUE_DEPTH 2

// operations accepted from issue but not yet consumed as results
`define AGU_CREDIT_LIMIT 2

`endif

/* hdl/agu_pkg.sv */
`include "agu_config.svh"

package agu_pkg;

    // kept load and store operations
    typedef enum logic [2:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_t;

    // one operation as it leaves issue
    typedef struct packed {
        mem_op_t                   op;
        logic [`AGU_XLEN-1:0]      base;
        logic [`AGU_OFFSET_W-1:0]  offset;
        logic [`AGU_XLEN-1:0]      store_value;
        logic [`AGU_DEST_W-1:0]    dest;
        logic [`AGU_ROB_W-1:0]     rob_tag;
    } mem_issue_t;

    // data cache request fields
    typedef struct packed {
        logic                  wr;
        logic [2:0]            size;
        logic [3:0]            wstrb;
        logic [`AGU_XLEN-1:0]  addr;
        logic [`AGU_XLEN-1:0]  wdata;
    } dcache_req_t;

    typedef struct packed {
        logic                  ex;
        logic [4:0]            exccode;
        logic [`AGU_XLEN-1:0]  badvaddr;
    } mem_exc_t;

    // what completion still needs once the request is on the bus
    typedef struct packed {
        mem_op_t                 op;
        logic [1:0]              addr_lo;
        logic [`AGU_DEST_W-1:0]  dest;
        logic [`AGU_ROB_W-1:0]   rob_tag;
        mem_exc_t                exc;
    } pending_op_t;

    // finished operation, in issue order
    typedef struct packed {
        logic [`AGU_ROB_W-1:0]   rob_tag;
        logic [`AGU_DEST_W-1:0]  dest;
        logic                    rf_we;
        logic [`AGU_XLEN-1:0]    value;
        mem_exc_t                exc;
    } mem_result_t;

endpackage

/* hdl/skid_queue.sv */
`timescale 1ns/1ns
`include "agu_config.svh"

module skid_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_pop,
    output payload_t out_data
);

    typedef enum logic [1:0] {
        EMPTY,
        ONE,
        TWO
    } q_state_t;

    q_state_t state, state_next;
    payload_t head_q, back_q;
    logic     push, pop;

    if (`AGU_QUEUE_DEPTH != 2) begin : g_depth_check
        $error("skid_queue is built for exactly two entries");
    end

    assign in_ready  = state != TWO;
    assign out_valid = state != EMPTY;
    assign out_data  = head_q;

    assign push = in_valid && in_ready;
    assign pop  = out_pop && out_valid;

    always_comb begin
        state_next = state;
        unique case (state)
            EMPTY: state_next = push ? ONE : EMPTY;
            ONE:   state_next = (push && !pop) ? TWO : ((pop && !push) ? EMPTY : ONE);
            TWO:   state_next = pop ? ONE : TWO;
            default: state_next = EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // head takes the input directly when it would otherwise go empty
    always_ff @(posedge clk) begin
        if ((state == EMPTY && push) || (state == ONE && push && pop)) begin
            head_q <= in_data;
        end else if (state == TWO && pop) begin
            head_q <= back_q;
        end

        if (state == ONE && push && !pop) begin
            back_q <= in_data;
        end
    end

    // the head waits unchanged until it is popped
    a_head_holds: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_pop) |=> (out_valid && $stable(out_data)))
        else $error("skid_queue head changed before it was popped");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        out_pop |-> out_valid)
        else $error("skid_queue popped while empty");

endmodule

/* hdl/credit_counter.sv */
`timescale 1ns/1ns
`include "agu_config.svh"

module credit_counter (
    input  logic clk,
    input  logic reset,

    input  logic take,
    input  logic give,
    output logic grant
);

    localparam int LIMIT = `AGU_CREDIT_LIMIT;
    localparam int CNT_W = $clog2(LIMIT + 1);

    logic [CNT_W-1:0] count;

    // room for one more operation in the result path
    assign grant = count < CNT_W'(LIMIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (take && !give) begin
            count <= count + 1'b1;
        end else if (give && !take && count != '0) begin
            count <= count - 1'b1;
        end
    end

    // take is only raised by dispatch while grant is high
    a_count_limit: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(LIMIT))
        else $error("credit count above limit");

endmodule

/* hdl/mem_access_format.sv */
`timescale 1ns/1ns
`include "agu_config.svh"

module mem_access_format
    import agu_pkg::*;
(
    input  mem_issue_t  op_in,
    output dcache_req_t req,
    output pending_op_t pend
);

    logic [`AGU_XLEN-1:0] addr;
    logic [`AGU_XLEN-1:0] offset_ext;
    logic [1:0]           lo;
    logic                 is_store;
    logic                 is_byte;
    logic                 is_half;
    logic                 misaligned;

    assign offset_ext = {{(`AGU_XLEN - `AGU_OFFSET_W){op_in.offset[`AGU_OFFSET_W-1]}},
                         op_in.offset};
    assign addr = op_in.base + offset_ext;
    assign lo   = addr[1:0];

    assign is_store = op_in.op inside {OP_SB, OP_SH, OP_SW};
    assign is_byte  = op_in.op inside {OP_LB, OP_LBU, OP_SB};
    assign is_half  = op_in.op inside {OP_LH, OP_LHU, OP_SH};

    // words need both low bits clear, halfwords only bit 0
    assign misaligned = (is_half && lo[0])
                     || (!is_byte && !is_half && lo != 2'b00);

    always_comb begin
        req.wr   = is_store;
        req.addr = addr;
        if (is_byte) begin
            req.size  = 3'd0;
            req.wstrb = 4'b0001 << lo;
            req.wdata = {4{op_in.store_value[7:0]}};
        end else if (is_half) begin
            req.size  = 3'd1;
            req.wstrb = 4'b0011 << lo;
            req.wdata = {2{op_in.store_value[15:0]}};
        end else begin
            req.size  = 3'd2;
            req.wstrb = 4'b1111;
            req.wdata = op_in.store_value;
        end
        // loads put nothing on the write data lanes
        if (!is_store) begin
            req.wdata = '0;
        end
    end

    always_comb begin
        pend.op       = op_in.op;
        pend.addr_lo  = lo;
        pend.dest     = op_in.dest;
        pend.rob_tag  = op_in.rob_tag;
        pend.exc      = '0;
        if (misaligned) begin
            pend.exc.ex       = 1'b1;
            pend.exc.exccode  = is_store ? `AGU_EXC_ADES : `AGU_EXC_ADEL;
            pend.exc.badvaddr = addr;
        end
    end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ns
`include "agu_config.svh"

module load_align
    import agu_pkg::*;
(
    input  pending_op_t          pend,
    input  logic [`AGU_XLEN-1:0] rdata,
    output mem_result_t          result
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        is_load;

    // lane picked by the low address bits
    always_comb begin
        unique case (pend.addr_lo)
            2'd0: byte_sel = rdata[7:0];
            2'd1: byte_sel = rdata[15:8];
            2'd2: byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = pend.addr_lo[1] ? rdata[31:16] : rdata[15:0];

    assign is_load = pend.op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};

    always_comb begin
        result.rob_tag = pend.rob_tag;
        result.dest    = pend.dest;
        result.exc     = pend.exc;
        result.rf_we   = is_load && !pend.exc.ex;
        result.value   = '0;
        if (result.rf_we) begin
            unique case (pend.op)
                OP_LB:   result.value = {{(`AGU_XLEN - 8){byte_sel[7]}}, byte_sel};
                OP_LBU:  result.value = {{(`AGU_XLEN - 8){1'b0}}, byte_sel};
                OP_LH:   result.value = {{(`AGU_XLEN - 16){half_sel[15]}}, half_sel};
                OP_LHU:  result.value = {{(`AGU_XLEN - 16){1'b0}}, half_sel};
                default: result.value = rdata;
            endcase
        end
    end

endmodule

/* hdl/mem_unit.sv */
`timescale 1ns/1ns
`include "agu_config.svh"

module mem_unit
    import agu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    // issue side
    input  logic                 issue_valid,
    output logic                 issue_allowin,
    input  mem_issue_t           issue,

    // data cache bus
    output logic                 dcache_req,
    output dcache_req_t          dcache,
    input  logic                 dcache_addr_ok,
    input  logic                 dcache_data_ok,
    input  logic [`AGU_XLEN-1:0] dcache_rdata,

    // in-order result stream
    output logic                 result_valid,
    input  logic                 result_ready,
    output mem_result_t          result
);

    mem_issue_t  iq_head;
    logic        iq_valid;
    logic        iq_pop;

    dcache_req_t fmt_req;
    pending_op_t fmt_pend;

    pending_op_t pend_head;
    logic        pend_valid;
    logic        pend_in_ready;

    mem_result_t done_result;
    logic        res_in_ready;
    logic        res_take;

    logic        grant;
    logic        dispatch_go;
    logic        exc_move;
    logic        complete;

    skid_queue #(.payload_t(mem_issue_t)) issue_q (
        .clk,
        .reset,
        .in_valid  (issue_valid),
        .in_ready  (issue_allowin),
        .in_data   (issue),
        .out_valid (iq_valid),
        .out_pop   (iq_pop),
        .out_data  (iq_head)
    );

    mem_access_format u_format (
        .op_in (iq_head),
        .req   (fmt_req),
        .pend  (fmt_pend)
    );

    credit_counter u_credit (
        .clk,
        .reset,
        .take  (iq_pop),
        .give  (res_take),
        .grant
    );

    // dispatch
    assign dispatch_go = iq_valid && grant && pend_in_ready;

    // an address error waits until nothing is outstanding on the bus
    assign exc_move = dispatch_go && fmt_pend.exc.ex && !pend_valid;

    assign dcache_req = dispatch_go && !fmt_pend.exc.ex;
    assign dcache     = fmt_req;

    assign iq_pop = exc_move || (dcache_req && dcache_addr_ok);

    skid_queue #(.payload_t(pending_op_t)) pend_q (
        .clk,
        .reset,
        .in_valid  (iq_pop),
        .in_ready  (pend_in_ready),
        .in_data   (fmt_pend),
        .out_valid (pend_valid),
        .out_pop   (complete),
        .out_data  (pend_head)
    );

    // completion
    assign complete = pend_valid && (pend_head.exc.ex || dcache_data_ok);

    load_align u_align (
        .pend   (pend_head),
        .rdata  (dcache_rdata),
        .result (done_result)
    );

    skid_queue #(.payload_t(mem_result_t)) res_q (
        .clk,
        .reset,
        .in_valid  (complete),
        .in_ready  (res_in_ready),
        .in_data   (done_result),
        .out_valid (result_valid),
        .out_pop   (res_take),
        .out_data  (result)
    );

    assign res_take = result_valid && result_ready;

    // data_ok belongs to the oldest accepted request
    a_data_ok_head: assert property (@(posedge clk) disable iff (reset)
        dcache_data_ok |-> (pend_valid && !pend_head.exc.ex))
        else $error("data_ok without a pending bus request at the head");

    // credits guarantee the result queue has room
    a_res_room: assert property (@(posedge clk) disable iff (reset)
        complete |-> res_in_ready)
        else $error("completion with a full result queue");

endmodule

/* dv/mem_unit_model.svh */
`ifndef MEM_UNIT_MODEL_SVH
`define MEM_UNIT_MODEL_SVH

// starting memory word that every index bit changes
function automatic logic [31:0] fill_word(input int idx);
    return (idx * 32'h0104_1041) ^ 32'h5a3c_96e1;
endfunction

function automatic int access_bytes(input mem_op_t op);
    case (op)
        OP_LB, OP_LBU, OP_SB: return 1;
        OP_LH, OP_LHU, OP_SH: return 2;
        default: return 4;
    endcase
endfunction

function automatic logic is_store_op(input mem_op_t op);
    return op == OP_SB || op == OP_SH || op == OP_SW;
endfunction

// base plus sign-extended offset
function automatic logic [31:0] effective_addr(input mem_issue_t op);
    logic signed [31:0] off;
    off = $signed(op.offset);
    return op.base + off;
endfunction

function automatic logic is_misaligned(input mem_issue_t op);
    return (effective_addr(op) % access_bytes(op.op)) != 0;
endfunction

function automatic dcache_req_t expected_req(input mem_issue_t op);
    dcache_req_t r;
    logic [1:0]  lo;
    int          n;
    int          j;
    r.addr = effective_addr(op);
    lo = r.addr[1:0];
    n = access_bytes(op.op);
    r.wr = is_store_op(op.op);
    r.size = (n == 1) ? 3'd0 : ((n == 2) ? 3'd1 : 3'd2);
    r.wstrb = '0;
    r.wdata = '0;
    for (j = 0; j < 4; j++) begin
        r.wstrb[j] = (j >= lo) && (j < lo + n);
        // store bytes repeat across the word
        if (r.wr)
            r.wdata[8*j +: 8] = op.store_value[8*(j % n) +: 8];
    end
    return r;
endfunction

function automatic logic [31:0] merge_store(input logic [31:0] old, input dcache_req_t r);
    logic [31:0] w;
    int          j;
    w = old;
    for (j = 0; j < 4; j++)
        if (r.wstrb[j])
            w[8*j +: 8] = r.wdata[8*j +: 8];
    return w;
endfunction

function automatic logic [31:0] extract_load(input mem_op_t op, input logic [31:0] word,
                                             input logic [1:0] lo);
    logic [31:0] raw;
    raw = word >> (8 * lo);
    case (op)
        OP_LB:   return {{24{raw[7]}}, raw[7:0]};
        OP_LBU:  return {24'd0, raw[7:0]};
        OP_LH:   return {{16{raw[15]}}, raw[15:0]};
        OP_LHU:  return {16'd0, raw[15:0]};
        default: return word;
    endcase
endfunction

function automatic mem_result_t expected_result(input mem_issue_t op, input logic [31:0] word);
    mem_result_t r;
    logic [31:0] a;
    a = effective_addr(op);
    r.rob_tag = op.rob_tag;
    r.dest = op.dest;
    r.exc = '0;
    r.rf_we = 1'b0;
    r.value = '0;
    if (is_misaligned(op)) begin
        r.exc.ex = 1'b1;
        r.exc.exccode = is_store_op(op.op) ? `AGU_EXC_ADES : `AGU_EXC_ADEL;
        r.exc.badvaddr = a;
    end else if (!is_store_op(op.op)) begin
        r.rf_we = 1'b1;
        r.value = extract_load(op.op, word, a[1:0]);
    end
    return r;
endfunction

`endif

/* dv/mem_unit_tb.sv */
`timescale 1ns/1ns
`include "agu_config.svh"

module mem_unit_tb
    import agu_pkg::*;
();

    localparam int NUM_OPS    = 400;
    localparam int WAIT_LIMIT = 300;

    logic        clk = 1'b0;
    logic        reset;
    logic        issue_valid, issue_allowin;
    mem_issue_t  issue;
    logic        dcache_req, dcache_addr_ok, dcache_data_ok;
    dcache_req_t dcache;
    logic [31:0] dcache_rdata;
    logic        result_valid, result_ready;
    mem_result_t result;

    // expected traffic with the oldest first
    dcache_req_t exp_req[$];
    mem_result_t exp_res[$];
    logic [31:0] ret_data[$];
    int          ret_due[$];

    logic [31:0] model_mem[64];
    logic [31:0] cache_mem[64];
    logic [31:0] issue_rng, cache_rng, ready_rng;
    int          cycle, outstanding, results_seen;
    logic        req_waiting;
    dcache_req_t held_req;

    `include "mem_unit_model.svh"

    mem_unit UUT (.clk, .reset, .issue_valid, .issue_allowin, .issue, .dcache_req, .dcache,
        .dcache_addr_ok, .dcache_data_ok, .dcache_rdata, .result_valid, .result_ready, .result);

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("error at %0t ns: %s", $time, what);
        abort_run();
    endtask

    task automatic check_req(input dcache_req_t got, input dcache_req_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: request wr %0b size %0d wstrb %b addr %h wdata %h",
                $time, got.wr, got.size, got.wstrb, got.addr, got.wdata);
            $display("    expected wr %0b size %0d wstrb %b addr %h wdata %h",
                exp.wr, exp.size, exp.wstrb, exp.addr, exp.wdata);
            abort_run();
        end
    endtask

    task automatic check_result(input mem_result_t got, input mem_result_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: result rob %0d dest %0d we %0b value %h exc %0b/%0d/%h",
                $time, got.rob_tag, got.dest, got.rf_we, got.value,
                got.exc.ex, got.exc.exccode, got.exc.badvaddr);
            $display("    expected rob %0d dest %0d we %0b value %h exc %0b/%0d/%h",
                exp.rob_tag, exp.dest, exp.rf_we, exp.value,
                exp.exc.ex, exp.exc.exccode, exp.exc.badvaddr);
            abort_run();
        end
    endtask

    task automatic make_op(input int seq, output mem_issue_t op);
        int n;
        issue_rng = xorshift32(issue_rng);
        op.op = mem_op_t'(issue_rng[2:0]);
        op.dest = issue_rng[8:3];
        op.rob_tag = seq[3:0];
        n = access_bytes(op.op);
        issue_rng = xorshift32(issue_rng);
        op.base = issue_rng;
        issue_rng = xorshift32(issue_rng);
        op.offset = issue_rng[15:0];
        // one in eight keeps random low bits
        if (issue_rng[31:29] != 3'd0) begin
            op.base[1:0] = 2'b00;
            if (n == 2)
                op.offset[0] = 1'b0;
            if (n == 4)
                op.offset[1:0] = 2'b00;
        end
        issue_rng = xorshift32(issue_rng);
        op.store_value = issue_rng;
    endtask

    // memory follows issue order just like the bus
    task automatic predict(input mem_issue_t op);
        dcache_req_t rq;
        logic [5:0]  idx;
        if (is_misaligned(op)) begin
            exp_res.push_back(expected_result(op, 32'd0));
        end else begin
            rq = expected_req(op);
            idx = rq.addr[7:2];
            exp_req.push_back(rq);
            exp_res.push_back(expected_result(op, model_mem[idx]));
            if (rq.wr)
                model_mem[idx] = merge_store(model_mem[idx], rq);
        end
    endtask

    initial begin : stimulus
        int         k, gap, waited;
        mem_issue_t op;
        issue_rng = 32'h1b36_0406;
        cache_rng = 32'h1b36_0406 ^ 32'h9e37_79b9;
        ready_rng = 32'h1b36_0406 ^ 32'h7f4a_7c15;
        cycle = 0;
        outstanding = 0;
        results_seen = 0;
        reset = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        for (k = 0; k < 64; k++) begin
            model_mem[k] = fill_word(k);
            cache_mem[k] = fill_word(k);
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        if (dcache_req !== 1'b0 || result_valid !== 1'b0 || issue_allowin !== 1'b1)
            report_error("outputs are not idle after reset");
        @(posedge clk);
        #1;
        for (k = 0; k < NUM_OPS; k++) begin
            make_op(k, op);
            issue_rng = xorshift32(issue_rng);
            gap = (issue_rng[1:0] == 2'b00) ? issue_rng[4:2] : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            issue_valid = 1'b1;
            issue = op;
            waited = 0;
            @(negedge clk);
            while (!issue_allowin) begin
                waited++;
                if (waited > WAIT_LIMIT)
                    report_error("timed out waiting for issue_allowin");
                @(negedge clk);
            end
            predict(op);
            @(posedge clk);
            #1 issue_valid = 1'b0;
        end
        waited = 0;
        while (results_seen < NUM_OPS) begin
            waited++;
            if (waited > WAIT_LIMIT)
                report_error("timed out waiting for the remaining results");
            @(negedge clk);
        end
        // a few idle cycles to catch extra requests or results
        repeat (20) @(negedge clk);
        if (exp_req.size() != 0 || exp_res.size() != 0 || outstanding != 0) begin
            report_error("operations left over at the end of the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial begin : cache_responder
        logic [5:0] idx;
        dcache_addr_ok = 1'b0;
        dcache_data_ok = 1'b0;
        dcache_rdata = '0;
        req_waiting = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cache_rng = xorshift32(cache_rng);
            dcache_addr_ok = cache_rng[1:0] != 2'b00;
            dcache_data_ok = ret_data.size() != 0 && cycle >= ret_due[0];
            dcache_rdata = dcache_data_ok ? ret_data[0] : cache_rng;
            @(negedge clk);
            if (!reset && req_waiting && (dcache_req !== 1'b1 || dcache !== held_req))
                report_error("request dropped or changed before addr_ok");
            req_waiting = !reset && dcache_req && !dcache_addr_ok;
            held_req = dcache;
            if (dcache_data_ok) begin
                void'(ret_data.pop_front());
                void'(ret_due.pop_front());
                outstanding--;
            end
            if (!reset && dcache_req && dcache_addr_ok) begin
                if (exp_req.size() == 0)
                    report_error("bus request for an operation that needs none");
                check_req(dcache, exp_req.pop_front());
                idx = dcache.addr[7:2];
                // stores get junk back on data_ok
                ret_data.push_back(dcache.wr ? cache_rng : cache_mem[idx]);
                ret_due.push_back(cycle + 1 + cache_rng[4:3]);
                if (dcache.wr)
                    cache_mem[idx] = merge_store(cache_mem[idx], dcache);
                outstanding++;
                if (outstanding > 2)
                    report_error("more than two bus requests waiting for data_ok");
            end
        end
    end

    initial begin : result_consumer
        result_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            ready_rng = xorshift32(ready_rng);
            // long stall now and then to run credits out
            result_ready = ready_rng[3:0] > 4'd5 && cycle[6:3] != 4'hf;
            @(negedge clk);
            if (!reset && result_valid && result_ready) begin
                if (exp_res.size() == 0)
                    report_error("result with no operation waiting for it");
                check_result(result, exp_res.pop_front());
                results_seen++;
            end
        end
    end

endmodule

/* sources.f */
+incdir+hdl
+incdir+dv
hdl/agu_pkg.sv
hdl/skid_queue.sv
hdl/credit_counter.sv
hdl/mem_access_format.sv
hdl/load_align.sv
hdl/mem_unit.sv
dv/mem_unit_tb.sv
